// ==== cam_defines.svh ====
`ifndef CAM_DEFINES_SVH
`define CAM_DEFINES_SVH

// ==============================
// camera frame buffer geometry
// ==============================
`define CAM_WIDTH   320                        // pixels per camera line
`define CAM_HEIGHT  240                        // camera lines per frame
`define CAM_PIXELS  (`CAM_WIDTH * `CAM_HEIGHT) // 76800 buffer words

// ==============================
// 640x480 raster, 25 MHz pixel clock
// ==============================
`define H_ACTIVE    640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48

`define V_ACTIVE    480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33

// reset values
`define DISPLAY_MODE_RESET  control_pkg::MODE_ORIG  // colour after reset
`define SYNC_IDLE           1'b1                    // syncs are active low

// luma weights, sum is 256 so >>8 gives 8-bit gray
`define LUMA_R      76
`define LUMA_G      150
`define LUMA_B      30

`endif

// ==== video_pkg.sv ====
`default_nettype none

`include "cam_defines.svh"

package video_pkg;

    // word address into the 320x240 buffer, 17 bits
    typedef logic [$clog2(`CAM_PIXELS)-1:0] buf_addr_t;

    // camera pixel as stored in memory
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // what goes to the DAC
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // capture -> buffer write port
    typedef struct packed {
        logic      en;    // one-cycle strobe per pixel
        buf_addr_t addr;
        rgb565_t   data;
    } cam_write_s;

    // raster state, combinational from the counters
    typedef struct packed {
        logic      hsync;        // active low
        logic      vsync;        // active low
        logic      active;       // inside 640x480
        logic      frame_start;  // h=0, v=0
        buf_addr_t addr;         // upscaled read address
    } raster_s;

endpackage

`default_nettype wire

// ==== control_pkg.sv ====
`default_nettype none

package control_pkg;

    // ==============================
    // display modes
    // ==============================
    typedef enum logic {
        MODE_ORIG = 1'b0,  // camera colours
        MODE_GRAY = 1'b1   // luma on all three channels
    } display_mode_e;

    // ==============================
    // IR remote key codes
    // ==============================
    // codes come already decoded from the receiver,
    // only two keys mean anything to the display path
    typedef enum logic [7:0] {
        KEY_A    = 8'h0F,  // grayscale
        KEY_ORIG = 8'h12   // 'OK' key, back to colour
    } ir_key_e;

endpackage

`default_nettype wire

// ==== ir_command_decoder.sv ====
`default_nettype none

`include "cam_defines.svh"

module ir_command_decoder (
    input  logic                      clk_25_vga,
    input  logic                      rst,
    input  logic [7:0]                ir_code,   // decoded key
    input  logic                      ir_valid,  // one strobe per key press
    output control_pkg::display_mode_e mode
);

    // ==============================
    // mode register
    // ==============================
    control_pkg::display_mode_e mode_q;
    control_pkg::display_mode_e mode_next;

    // pick the new mode from the key, anything unknown keeps the old one
    always_comb begin
        mode_next = mode_q;
        if (ir_valid) begin
            case (ir_code)
                control_pkg::KEY_ORIG: mode_next = control_pkg::MODE_ORIG;
                control_pkg::KEY_A:    mode_next = control_pkg::MODE_GRAY;
                default:               mode_next = mode_q;  // ignore other keys
            endcase
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            mode_q <= `DISPLAY_MODE_RESET;
        end else begin
            mode_q <= mode_next;  // takes effect the cycle after ir_valid
        end
    end

    assign mode = mode_q;

endmodule

`default_nettype wire

// ==== camera_capture.sv ====
`default_nettype none

`include "cam_defines.svh"

module camera_capture (
    input  logic                    clk_25_vga,
    input  logic                    rst,
    input  logic                    cam_vsync,
    input  logic                    cam_href,
    input  logic [7:0]              cam_data,
    output video_pkg::cam_write_s   wr,
    output logic                    frame_done  // sticky after the first full frame
);

    localparam video_pkg::buf_addr_t LAST_ADDR = video_pkg::buf_addr_t'(`CAM_PIXELS - 1);

    logic                  vsync_q;     // previous cam_vsync
    logic                  vsync_fall;  // new frame begins
    logic                  byte_phase;  // 0 = high byte expected
    logic [7:0]            hi_byte;
    logic                  wr_en;
    video_pkg::buf_addr_t  wr_addr;
    video_pkg::rgb565_t    wr_data;
    video_pkg::buf_addr_t  next_addr;   // address for the coming pixel

    assign vsync_fall = vsync_q & ~cam_vsync;

    // ==============================
    // phase, strobe, address and done flag
    // ==============================
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            vsync_q    <= 1'b0;
            byte_phase <= 1'b0;
            wr_en      <= 1'b0;
            next_addr  <= '0;
            frame_done <= 1'b0;
        end else begin
            vsync_q <= cam_vsync;
            wr_en   <= 1'b0;                       // strobe by default low
            if (vsync_fall) begin
                next_addr  <= '0;                  // restart at top left
                byte_phase <= 1'b0;
            end else if (cam_href) begin
                byte_phase <= ~byte_phase;
                if (byte_phase) begin              // low byte completes the pixel
                    wr_en     <= 1'b1;
                    next_addr <= (next_addr == LAST_ADDR) ? '0 : next_addr + 1'b1;
                end
            end else begin
                byte_phase <= 1'b0;                // realign on every line
            end
            // last word of the frame is going into memory now
            if (wr_en && (wr_addr == LAST_ADDR)) begin
                frame_done <= 1'b1;
            end
        end
    end

    // pixel payload from the byte pair
    always_ff @(posedge clk_25_vga) begin
        if (cam_href && !byte_phase) begin
            hi_byte <= cam_data;                   // RRRRRGGG
        end
        if (cam_href && byte_phase && !vsync_fall) begin
            wr_addr <= next_addr;
            wr_data <= {hi_byte, cam_data};        // GGGBBBBB in the low byte
        end
    end

    assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// ==== frame_buffer.sv ====
`default_nettype none

`include "cam_defines.svh"

module frame_buffer (
    input  logic                   clk_25_vga,
    input  video_pkg::cam_write_s  wr,       // from capture
    input  video_pkg::buf_addr_t   rd_addr,  // from raster
    output video_pkg::rgb565_t     rd_data   // one cycle after rd_addr
);

    // ==============================
    // one 76800 x 16 memory
    // ==============================
    // one writer, one reader, so no arbitration at all
    video_pkg::rgb565_t mem [`CAM_PIXELS];

    // write port, camera side
    always_ff @(posedge clk_25_vga) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port, registered every cycle
    always_ff @(posedge clk_25_vga) begin
        rd_data <= mem[rd_addr];  // block RAM style
    end

endmodule

`default_nettype wire

// ==== vga_timing.sv ====
`default_nettype none

`include "cam_defines.svh"

module vga_timing (
    input  logic                clk_25_vga,
    input  logic                rst,
    output video_pkg::raster_s  raster
);

    // ==============================
    // raster windows
    // ==============================
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
    localparam int H_TOTAL      = H_SYNC_END + `H_BACK;    // 800
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;
    localparam int V_TOTAL      = V_SYNC_END + `V_BACK;    // 525

    logic [9:0]            h_cnt;
    logic [9:0]            v_cnt;
    logic                  active;
    logic                  hsync_n;
    logic                  vsync_n;
    logic [8:0]            h_half;     // camera column
    logic [8:0]            v_half;     // camera row
    video_pkg::buf_addr_t  row_base;
    video_pkg::buf_addr_t  pix_addr;

    // counters
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == 10'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == 10'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;  // next line
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ==============================
    // decode, no extra latency
    // ==============================
    assign active  = (h_cnt < 10'(`H_ACTIVE)) && (v_cnt < 10'(`V_ACTIVE));
    assign hsync_n = ~((h_cnt >= 10'(H_SYNC_START)) && (h_cnt < 10'(H_SYNC_END)));
    assign vsync_n = ~((v_cnt >= 10'(V_SYNC_START)) && (v_cnt < 10'(V_SYNC_END)));

    // 2x upscale, each buffer pixel covers a 2x2 block
    assign h_half   = h_cnt[9:1];
    assign v_half   = v_cnt[9:1];
    assign row_base = video_pkg::buf_addr_t'(v_half) * video_pkg::buf_addr_t'(`CAM_WIDTH);
    assign pix_addr = active ? row_base + video_pkg::buf_addr_t'(h_half) : '0;

    assign raster = '{
        hsync:       hsync_n,
        vsync:       vsync_n,
        active:      active,
        frame_start: (h_cnt == '0) && (v_cnt == '0),
        addr:        pix_addr
    };

endmodule

`default_nettype wire

// ==== pixel_pipeline.sv ====
`default_nettype none

`include "cam_defines.svh"

module pixel_pipeline (
    input  logic                       clk_25_vga,
    input  logic                       rst,
    input  video_pkg::raster_s         raster,      // cycle 0
    input  video_pkg::rgb565_t         rd_data,     // cycle 1
    input  control_pkg::display_mode_e mode,
    input  logic                       frame_done,
    output video_pkg::rgb888_t         vga_rgb,     // cycle 2
    output logic                       vga_hsync,
    output logic                       vga_vsync,
    output logic                       vga_blank_n
);

    // raster controls lined up with rd_data
    logic                hsync_d;
    logic                vsync_d;
    logic                active_d;
    logic                disp_en;     // one full camera frame is in memory
    video_pkg::rgb888_t  color_px;
    video_pkg::rgb888_t  gray_px;
    video_pkg::rgb888_t  sel_px;
    logic [15:0]         luma_sum;
    logic [7:0]          luma;

    // ==============================
    // stage 0 -> 1, match buffer latency
    // ==============================
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            hsync_d  <= `SYNC_IDLE;
            vsync_d  <= `SYNC_IDLE;
            active_d <= 1'b0;
        end else begin
            hsync_d  <= raster.hsync;
            vsync_d  <= raster.vsync;
            active_d <= raster.active;
        end
    end

    // display turns on at a frame boundary once the buffer is filled,
    // raw frame_start so pixel (0,0) already sees it
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            disp_en <= 1'b0;
        end else if (raster.frame_start && frame_done) begin
            disp_en <= 1'b1;
        end
    end

    // ==============================
    // colour and gray
    // ==============================
    // low bits padded with ones, full white stays 8'hFF
    assign color_px = '{
        r: {rd_data.r, 3'b111},
        g: {rd_data.g, 2'b11},
        b: {rd_data.b, 3'b111}
    };

    // max 255*256, fits 16 bits
    assign luma_sum = 16'(`LUMA_R) * 16'(color_px.r)
                    + 16'(`LUMA_G) * 16'(color_px.g)
                    + 16'(`LUMA_B) * 16'(color_px.b);
    assign luma     = luma_sum[15:8];  // /256
    assign gray_px  = '{r: luma, g: luma, b: luma};

    always_comb begin
        case (mode)
            control_pkg::MODE_GRAY: sel_px = gray_px;
            default:                sel_px = color_px;  // MODE_ORIG
        endcase
    end

    // ==============================
    // stage 1 -> 2, output register
    // ==============================
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            vga_rgb     <= '0;
            vga_hsync   <= `SYNC_IDLE;
            vga_vsync   <= `SYNC_IDLE;
            vga_blank_n <= 1'b0;
        end else begin
            vga_hsync   <= hsync_d;
            vga_vsync   <= vsync_d;
            vga_blank_n <= active_d;
            vga_rgb     <= (active_d && disp_en) ? sel_px : '0;  // black in blanking
        end
    end

endmodule

`default_nettype wire

// ==== digital_cam_top.sv ====
`default_nettype none

module digital_cam_top (
    input  logic       clk_25_vga,
    input  logic       rst,
    // decoded IR remote
    input  logic [7:0] ir_code,
    input  logic       ir_valid,
    // camera byte stream
    input  logic       cam_vsync,
    input  logic       cam_href,
    input  logic [7:0] cam_data,
    // VGA
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic       vga_blank_n
);

    video_pkg::cam_write_s       cam_wr;
    logic                        frame_done;
    video_pkg::raster_s          raster;
    video_pkg::rgb565_t          rd_data;
    control_pkg::display_mode_e  mode;
    video_pkg::rgb888_t          vga_rgb;

    // ==============================
    // write side
    // ==============================
    camera_capture capture_inst (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .cam_vsync  (cam_vsync),
        .cam_href   (cam_href),
        .cam_data   (cam_data),
        .wr         (cam_wr),
        .frame_done (frame_done)
    );

    frame_buffer buffer_inst (
        .clk_25_vga (clk_25_vga),
        .wr         (cam_wr),
        .rd_addr    (raster.addr),
        .rd_data    (rd_data)
    );

    // ==============================
    // read side
    // ==============================
    vga_timing vga_inst (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .raster     (raster)
    );

    ir_command_decoder ir_inst (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .ir_code    (ir_code),
        .ir_valid   (ir_valid),
        .mode       (mode)
    );

    pixel_pipeline pipe_inst (
        .clk_25_vga  (clk_25_vga),
        .rst         (rst),
        .raster      (raster),
        .rd_data     (rd_data),
        .mode        (mode),
        .frame_done  (frame_done),
        .vga_rgb     (vga_rgb),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_blank_n (vga_blank_n)
    );

    assign vga_r = vga_rgb.r;
    assign vga_g = vga_rgb.g;
    assign vga_b = vga_rgb.b;

endmodule

`default_nettype wire

// ==== tb_digital_cam_top.sv ====
`default_nettype none

`include "cam_defines.svh"

module tb_digital_cam_top;

    localparam int H_TOTAL      = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;  // 800
    localparam int V_TOTAL      = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;  // 525
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int OP_FRAME     = 0;
    localparam int OP_KEY       = 1;
    localparam int OP_CHECK     = 2;

    logic       clk_25_vga = 1'b0;
    logic       rst;
    logic [7:0] ir_code;
    logic       ir_valid;
    logic       cam_vsync;
    logic       cam_href;
    logic [7:0] cam_data;
    logic [7:0] vga_r;
    logic [7:0] vga_g;
    logic [7:0] vga_b;
    logic       vga_hsync;
    logic       vga_vsync;
    logic       vga_blank_n;

    // command list and run limit
    int          op_q[$];
    int          arg_q[$];
    int          cycle_limit = 0;
    int          cycle_count = 0;
    // reference frame and expected display state
    logic [15:0] model [`CAM_PIXELS];
    logic        model_loaded = 1'b0;  // a full frame has been sent
    logic        gray_mode    = 1'b0;
    int          frames_req   = 0;     // display frames asked for
    int          frames_chk   = 0;     // display frames compared
    // raster tracking from the output syncs
    int          pos_x   = 0;
    int          pos_y   = 0;
    int          hs_low  = 0;
    int          vs_low  = 0;
    logic        h_lock  = 1'b0;
    logic        v_lock  = 1'b0;
    logic        hs_prev = 1'b1;
    logic        vs_prev = 1'b1;
    logic        in_frame = 1'b0;
    logic        fr_en    = 1'b0;
    logic        fr_gray  = 1'b0;
    logic        disp_on  = 1'b0;  // display expected to be showing the buffer

    digital_cam_top i_dut (
        .clk_25_vga  (clk_25_vga),
        .rst         (rst),
        .ir_code     (ir_code),
        .ir_valid    (ir_valid),
        .cam_vsync   (cam_vsync),
        .cam_href    (cam_href),
        .cam_data    (cam_data),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_blank_n (vga_blank_n)
    );

    always #20 clk_25_vga = ~clk_25_vga;  // 25 MHz pixel clock

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic fail_value(input string sig, input logic [31:0] expv,
                              input logic [31:0] actv);
        stop_run($sformatf("[FAIL] t=%0t x=%0d y=%0d %s expected %0h got %0h",
                           $time, pos_x, pos_y, sig, expv, actv));
    endtask

    // RGB565 expanded with ones in the low bits, or gray from the luma weights
    function automatic logic [23:0] expected_pixel(input logic [15:0] word,
                                                   input logic gray);
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        int         luma;
        r8   = {word[15:11], 3'b111};
        g8   = {word[10:5], 2'b11};
        b8   = {word[4:0], 3'b111};
        luma = (`LUMA_R * int'(r8) + `LUMA_G * int'(g8) + `LUMA_B * int'(b8)) / 256;
        if (gray) begin
            expected_pixel = {3{8'(luma)}};
        end else begin
            expected_pixel = {r8, g8, b8};
        end
    endfunction

    // ==============================
    // stimulus file
    // ==============================
    task automatic load_stimulus();
        int          fd;
        int          code;
        int          arg;
        int          ch;
        int          frames_total;
        int          check_total;
        logic        done;
        logic [63:0] word;
        frames_total = 0;
        check_total  = 0;
        done         = 1'b0;
        fd = $fopen("cam_stimulus.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open cam_stimulus.txt");
        end
        while (!done) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) begin
                done = 1'b1;                         // end of file
            end else if (word == 64'("#")) begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin  // rest of the comment line
                    ch = $fgetc(fd);
                end
            end else if (word == 64'("frame")) begin
                op_q.push_back(OP_FRAME);
                arg_q.push_back(0);
                frames_total++;
            end else if (word == 64'("key")) begin
                code = $fscanf(fd, "%h", arg);
                if (code != 1) begin
                    stop_run("key command in stimulus file has no code");
                end
                op_q.push_back(OP_KEY);
                arg_q.push_back(arg);
            end else if (word == 64'("check")) begin
                code = $fscanf(fd, "%d", arg);
                if (code != 1) begin
                    stop_run("check command in stimulus file has no frame count");
                end
                op_q.push_back(OP_CHECK);
                arg_q.push_back(arg);
                check_total += arg + 1;              // +1 for lining up to a frame start
            end else begin
                stop_run("unknown command in stimulus file");
            end
        end
        $fclose(fd);
        cycle_limit = (frames_total * 160000 + check_total * 420000) * 12 / 10;
    endtask

    // ==============================
    // drivers on the falling edge
    // ==============================
    task automatic send_frame();
        int          row;
        int          col;
        logic [15:0] px;
        cam_vsync = 1'b1;
        repeat (4) @(negedge clk_25_vga);
        cam_vsync = 1'b0;                            // falling edge starts the frame
        repeat (4) @(negedge clk_25_vga);
        for (row = 0; row < `CAM_HEIGHT; row++) begin
            for (col = 0; col < `CAM_WIDTH; col++) begin
                px = 16'($urandom);
                model[17'(row * `CAM_WIDTH + col)] = px;
                cam_href = 1'b1;
                cam_data = px[15:8];                 // high byte first
                @(negedge clk_25_vga);
                cam_data = px[7:0];
                @(negedge clk_25_vga);
            end
            cam_href = 1'b0;
            cam_data = '0;
            repeat (16) @(negedge clk_25_vga);       // line gap
        end
        model_loaded <= 1'b1;
    endtask

    task automatic press_key(input logic [7:0] code);
        ir_code  = code;
        ir_valid = 1'b1;
        @(negedge clk_25_vga);
        ir_valid = 1'b0;
        ir_code  = '0;
        if (code == control_pkg::KEY_A) begin
            gray_mode <= 1'b1;
        end else if (code == control_pkg::KEY_ORIG) begin
            gray_mode <= 1'b0;
        end                                          // other codes keep the mode
    endtask

    task automatic check_frames(input int count);
        frames_req <= frames_req + count;
        @(negedge clk_25_vga);
        while (frames_chk != frames_req) begin
            @(negedge clk_25_vga);
        end
    endtask

    // ==============================
    // output monitor sampling mid cycle
    // ==============================
    always @(negedge clk_25_vga) begin : raster_monitor
        int          nx;
        int          ny;
        int          idx;
        logic        act;
        logic [23:0] exp_rgb;
        logic [23:0] got_rgb;
        nx = (pos_x == H_TOTAL - 1) ? 0 : pos_x + 1;
        ny = pos_y;
        if (pos_x == H_TOTAL - 1) begin
            ny = (pos_y == V_TOTAL - 1) ? 0 : pos_y + 1;
        end
        if (hs_prev && !vga_hsync) begin             // hsync fall is x = 656
            if (h_lock) begin
                assert (nx == H_SYNC_START)
                    else fail_value("vga_hsync fall x", 32'(H_SYNC_START), 32'(nx));
            end
            nx     = H_SYNC_START;
            h_lock = 1'b1;
        end
        if (!hs_prev && vga_hsync) begin
            assert (hs_low == `H_SYNC)
                else fail_value("vga_hsync low width", 32'(`H_SYNC), 32'(hs_low));
        end
        hs_low = vga_hsync ? 0 : hs_low + 1;
        if (vs_prev && !vga_vsync) begin             // vsync falls at x 0 of line 490
            if (v_lock) begin
                assert (ny == V_SYNC_START)
                    else fail_value("vga_vsync fall y", 32'(V_SYNC_START), 32'(ny));
            end
            if (h_lock) begin
                assert (nx == 0) else fail_value("vga_vsync fall x", 32'(0), 32'(nx));
                v_lock = 1'b1;
            end
            ny = V_SYNC_START;
        end
        if (!vs_prev && vga_vsync) begin
            assert (vs_low == `V_SYNC * H_TOTAL)
                else fail_value("vga_vsync low width", 32'(`V_SYNC * H_TOTAL), 32'(vs_low));
        end
        vs_low  = vga_vsync ? 0 : vs_low + 1;
        pos_x   = nx;
        pos_y   = ny;
        hs_prev = vga_hsync;
        vs_prev = vga_vsync;
        if (h_lock && v_lock) begin
            act = (pos_x < `H_ACTIVE) && (pos_y < `V_ACTIVE);
            assert (vga_blank_n == act)
                else fail_value("vga_blank_n", 32'(act), 32'(vga_blank_n));
            if (pos_x == 0 && pos_y == 0 && model_loaded) begin
                disp_on = 1'b1;                      // display starts only at a frame start
            end
            if (!in_frame && frames_chk != frames_req && pos_x == 0 && pos_y == 0) begin
                in_frame = 1'b1;                     // state frozen for the whole frame
                fr_en    = model_loaded;
                fr_gray  = gray_mode;
            end
            exp_rgb = '0;
            if (act && in_frame && fr_en) begin
                idx     = (pos_y / 2) * `CAM_WIDTH + pos_x / 2;  // 2x upscale
                exp_rgb = expected_pixel(model[17'(idx)], fr_gray);
            end
            got_rgb = {vga_r, vga_g, vga_b};
            if (!act || in_frame || !disp_on) begin  // black in blanking and before display on
                assert (got_rgb == exp_rgb)
                    else fail_value("{vga_r,vga_g,vga_b}", 32'(exp_rgb), 32'(got_rgb));
            end
            if (in_frame && pos_x == H_TOTAL - 1 && pos_y == V_TOTAL - 1) begin
                in_frame = 1'b0;
                frames_chk <= frames_chk + 1;
            end
        end
    end

    always @(posedge clk_25_vga) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            stop_run($sformatf("timeout after %0d cycles, stimulus did not complete",
                               cycle_count));
        end
    end

    // ==============================
    // main sequence
    // ==============================
    initial begin : run_stimulus
        int idx;
        rst       = 1'b1;
        ir_code   = '0;
        ir_valid  = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_data  = '0;
        void'($urandom(54226));
        load_stimulus();
        repeat (2) @(negedge clk_25_vga);
        rst = 1'b0;
        for (idx = 0; idx < op_q.size(); idx++) begin
            case (op_q[idx])
                OP_FRAME: send_frame();
                OP_KEY:   press_key(8'(arg_q[idx]));
                default:  check_frames(arg_q[idx]);
            endcase
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cam_stimulus.txt ====
# one command per line, first column is the command
# frame = send camera frame, key <hex code> = IR key, check <n> = compare n display frames
check 1
frame
check 1
key 0F
check 1
# unknown code, stays gray
key 33
check 1
key 12
check 1
# second frame replaces the buffer
frame
check 1

// ==== digital_cam_top.f ====
+incdir+.
video_pkg.sv
control_pkg.sv
ir_command_decoder.sv
camera_capture.sv
frame_buffer.sv
vga_timing.sv
pixel_pipeline.sv
digital_cam_top.sv
tb_digital_cam_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the camera to VGA testbench, exit status follows the result
verilator --binary --timing --assert -j 0 --top-module tb_digital_cam_top \
    -f digital_cam_top.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "simulation failed"; exit 1; }
